// ==== include/board_config.svh ====
`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// ------------------------------
// board geometry
// ------------------------------
`define BOARD_NUM_AXES 4        // axis channels 1..4

// ------------------------------
// address map
// ------------------------------
// space select, reg addr bits 15..12
`define ADDR_MAIN 4'h0          // board + axis registers
`define ADDR_HUB  4'h1          // hub memory

// register offset within a channel, bits 3..0
`define OFF_STATUS   4'h0       // chan 0 status / enables
`define OFF_DAC_CTRL 4'h1       // axis current command

`define HUB_DEPTH 64            // hub words, index from addr bits 5..0

// overcurrent cycles in a row before the amp gets cut
`define SAFETY_COUNT 4

`endif

// ==== design/board_pkg.sv ====
`include "board_config.svh"

package board_pkg;

    // ------------------------------
    // register bus
    // ------------------------------
    typedef logic [15:0] reg_addr_t;    // space | ... | chan | offset
    typedef logic [31:0] reg_data_t;    // one quadlet

    // ------------------------------
    // per-axis current values
    // ------------------------------
    // raw dac / adc counts, unsigned
    typedef logic [15:0] axis_cur_t;

    // bit 0 belongs to axis 1
    typedef logic [`BOARD_NUM_AXES-1:0] axis_mask_t;

    // element [0] belongs to axis 1
    typedef axis_cur_t [`BOARD_NUM_AXES-1:0] axis_cur_vec_t;

endpackage

// ==== design/reg_bus_arbiter.sv ====
`include "board_config.svh"

module reg_bus_arbiter (
    input  logic                 sysclk,
    input  logic                 rst,
    // fw link
    input  board_pkg::reg_addr_t fw_reg_raddr,
    input  board_pkg::reg_addr_t fw_reg_waddr,
    input  board_pkg::reg_data_t fw_reg_wdata,
    input  logic                 fw_reg_wen,
    input  logic                 fw_blk_wen,
    // eth link
    input  logic                 eth_read_en,   // eth owns the read address
    input  board_pkg::reg_addr_t eth_reg_raddr,
    input  board_pkg::reg_addr_t eth_reg_waddr,
    input  board_pkg::reg_data_t eth_reg_wdata,
    input  logic                 eth_reg_wen,
    input  logic                 eth_blk_wen,
    // registered read data from the peripherals
    input  board_pkg::reg_data_t hub_rdata,
    input  board_pkg::reg_data_t dac_rdata,
    input  board_pkg::reg_data_t board_rdata,
    // shared bus
    output board_pkg::reg_addr_t reg_raddr,
    output board_pkg::reg_addr_t reg_waddr,
    output board_pkg::reg_data_t reg_wdata,
    output logic                 reg_wen,
    output logic                 blk_wen,
    output board_pkg::reg_data_t reg_rdata,
    output logic                 fw_wr_drop     // fw write lost to eth
);

    logic       fw_wr;          // fw strobing either enable
    logic       eth_wr;         // same for eth
    logic [3:0] rd_space;       // read addr fields, one cycle old
    logic [3:0] rd_chan;
    logic [3:0] rd_off;
    logic       sel_hub;
    logic       sel_board;
    logic       sel_dac;

    // ------------------------------
    // write side, eth wins
    // ------------------------------
    assign fw_wr  = fw_reg_wen | fw_blk_wen;
    assign eth_wr = eth_reg_wen | eth_blk_wen;

    assign reg_waddr = eth_wr ? eth_reg_waddr : fw_reg_waddr;
    assign reg_wdata = eth_wr ? eth_reg_wdata : fw_reg_wdata;
    assign reg_wen   = fw_reg_wen | eth_reg_wen;   // plain OR, no handshake
    assign blk_wen   = fw_blk_wen | eth_blk_wen;

    // read address follows eth_read_en level
    assign reg_raddr = eth_read_en ? eth_reg_raddr : fw_reg_raddr;

    always_ff @(posedge sysclk) begin
        if (rst) begin
            fw_wr_drop <= 1'b0;
            rd_space   <= '0;
            rd_chan    <= '0;
            rd_off     <= '0;
        end else begin
            fw_wr_drop <= fw_wr & eth_wr;   // collision flag, next cycle
            rd_space   <= reg_raddr[15:12];
            rd_chan    <= reg_raddr[7:4];
            rd_off     <= reg_raddr[3:0];
        end
    end

    // ------------------------------
    // read steering
    // ------------------------------
    // decode lines up with the peripherals' registered data
    assign sel_hub   = (rd_space == `ADDR_HUB);
    assign sel_board = (rd_space == `ADDR_MAIN) && (rd_chan == 4'd0) &&
                       (rd_off == `OFF_STATUS);
    assign sel_dac   = (rd_space == `ADDR_MAIN) && (rd_off == `OFF_DAC_CTRL) &&
                       (rd_chan >= 4'd1) && (rd_chan <= 4'(`BOARD_NUM_AXES));

    always_comb begin
        if (sel_hub)
            reg_rdata = hub_rdata;
        else if (sel_board)
            reg_rdata = board_rdata;
        else if (sel_dac)
            reg_rdata = dac_rdata;
        else
            reg_rdata = '0;     // unmapped
    end

endmodule

// ==== design/hub_mem.sv ====
`include "board_config.svh"

module hub_mem (
    input  logic                 sysclk,
    input  board_pkg::reg_addr_t reg_raddr,
    input  board_pkg::reg_addr_t reg_waddr,
    input  board_pkg::reg_data_t reg_wdata,
    input  logic                 reg_wen,
    input  logic                 blk_wen,   // block writes fill the hub too
    output board_pkg::reg_data_t hub_rdata
);

    localparam int HUB_AW = $clog2(`HUB_DEPTH);    // word index bits

    board_pkg::reg_data_t mem [`HUB_DEPTH];
    logic                 hub_wr;

    // either strobe lands a word, hub space only
    assign hub_wr = (reg_wen | blk_wen) && (reg_waddr[15:12] == `ADDR_HUB);

    // ------------------------------
    // storage, sync read
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (hub_wr) begin
            mem[reg_waddr[HUB_AW-1:0]] <= reg_wdata;
        end
        // read every cycle, arbiter decides if it counts
        hub_rdata <= mem[reg_raddr[HUB_AW-1:0]];    // old data on same-addr write
    end

endmodule

// ==== design/dac_regs.sv ====
`include "board_config.svh"

module dac_regs (
    input  logic                     sysclk,
    input  logic                     rst,
    input  board_pkg::reg_addr_t     reg_raddr,
    input  board_pkg::reg_addr_t     reg_waddr,
    input  board_pkg::reg_data_t     reg_wdata,
    input  logic                     reg_wen,
    output board_pkg::axis_cur_vec_t cur_cmd,   // straight to the dacs
    output board_pkg::reg_data_t     dac_rdata
);

    localparam int AXIS_W = $clog2(`BOARD_NUM_AXES);   // axis index bits

    logic       wr_dac;     // write aimed at some axis dac reg
    logic [3:0] rd_chan;
    logic       rd_axis;    // read chan is 1..N

    assign wr_dac = reg_wen && (reg_waddr[15:12] == `ADDR_MAIN) &&
                    (reg_waddr[3:0] == `OFF_DAC_CTRL);

    assign rd_chan = reg_raddr[7:4];
    assign rd_axis = (rd_chan >= 4'd1) && (rd_chan <= 4'(`BOARD_NUM_AXES));

    // ------------------------------
    // command registers
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            cur_cmd <= '0;
        end else begin
            for (int i = 0; i < `BOARD_NUM_AXES; i++) begin
                // chan i+1 holds axis i
                if (wr_dac && (reg_waddr[7:4] == 4'(i + 1))) begin
                    cur_cmd[i] <= reg_wdata[15:0];  // low half only
                end
            end
        end
    end

    // zero-extended readback
    always_ff @(posedge sysclk) begin
        if (rst) begin
            dac_rdata <= '0;
        end else if (rd_axis) begin
            dac_rdata <= board_pkg::reg_data_t'(cur_cmd[AXIS_W'(rd_chan - 4'd1)]);
        end else begin
            dac_rdata <= '0;
        end
    end

endmodule

// ==== design/safety_check.sv ====
`include "board_config.svh"

module safety_check (
    input  logic                     sysclk,
    input  logic                     rst,
    input  board_pkg::axis_cur_vec_t cur_fb,            // measured current
    input  board_pkg::axis_cur_vec_t cur_cmd,           // commanded current
    input  board_pkg::axis_mask_t    safety_clear,      // one-cycle pulses
    output board_pkg::axis_mask_t    safety_disable     // latched, per axis
);

    localparam int CNT_W = $clog2(`SAFETY_COUNT + 1);
    // last count value before the latch fires
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SAFETY_COUNT - 1);

    logic [CNT_W-1:0]      over_cnt [`BOARD_NUM_AXES];  // consecutive hits
    board_pkg::axis_mask_t over;                        // fb > 2 * cmd this cycle

    // ------------------------------
    // compare, one bit wider
    // ------------------------------
    always_comb begin
        for (int i = 0; i < `BOARD_NUM_AXES; i++) begin
            over[i] = {1'b0, cur_fb[i]} > {cur_cmd[i], 1'b0};   // cmd << 1, no overflow
        end
    end

    // ------------------------------
    // filter + latch
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            over_cnt       <= '{default: '0};
            safety_disable <= '0;
        end else begin
            for (int i = 0; i < `BOARD_NUM_AXES; i++) begin
                if (safety_clear[i]) begin
                    // clear beats a same-cycle overcurrent
                    over_cnt[i]       <= '0;
                    safety_disable[i] <= 1'b0;
                end else if (over[i]) begin
                    if (over_cnt[i] == CNT_LAST)
                        safety_disable[i] <= 1'b1;      // Nth hit in a row
                    else
                        over_cnt[i] <= over_cnt[i] + 1'b1;  // saturates at CNT_LAST
                end else begin
                    over_cnt[i] <= '0;  // any quiet cycle restarts the run
                end
            end
        end
    end

endmodule

// ==== design/board_regs.sv ====
`include "board_config.svh"

module board_regs (
    input  logic                  sysclk,
    input  logic                  rst,
    input  board_pkg::reg_addr_t  reg_raddr,
    input  board_pkg::reg_addr_t  reg_waddr,
    input  board_pkg::reg_data_t  reg_wdata,
    input  logic                  reg_wen,
    input  board_pkg::axis_mask_t safety_disable,   // from safety_check
    output board_pkg::axis_mask_t safety_clear,     // back to safety_check
    output board_pkg::axis_mask_t amp_enable,       // to the amplifiers
    output board_pkg::reg_data_t  board_rdata
);

    board_pkg::axis_mask_t amp_reg;     // requested amp enables
    logic                  pwr_en;      // board power enable
    logic                  wr_status;
    logic                  rd_status;

    // chan 0, status offset
    assign wr_status = reg_wen && (reg_waddr[15:12] == `ADDR_MAIN) &&
                       (reg_waddr[7:4] == 4'd0) && (reg_waddr[3:0] == `OFF_STATUS);
    assign rd_status = (reg_raddr[15:12] == `ADDR_MAIN) &&
                       (reg_raddr[7:4] == 4'd0) && (reg_raddr[3:0] == `OFF_STATUS);

    // ------------------------------
    // enable registers
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            amp_reg <= '0;
            pwr_en  <= 1'b0;
        end else if (wr_status) begin
            amp_reg <= reg_wdata[`BOARD_NUM_AXES-1:0];
            pwr_en  <= reg_wdata[8];
        end
    end

    // writing a 1 to amp or pwr rearms the safety latch
    // pulse lasts as long as the strobe, i.e. one cycle
    assign safety_clear = wr_status ?
        (reg_wdata[`BOARD_NUM_AXES-1:0] | {`BOARD_NUM_AXES{reg_wdata[8]}}) : '0;

    // gated by power and by any tripped safety latch
    assign amp_enable = amp_reg & {`BOARD_NUM_AXES{pwr_en}} & ~safety_disable;

    // ------------------------------
    // status readback
    // ------------------------------
    // 8 = pwr, 7..4 = safety disable, 3..0 = amp reg
    always_ff @(posedge sysclk) begin
        if (rst) begin
            board_rdata <= '0;
        end else if (rd_status) begin
            board_rdata <= board_pkg::reg_data_t'({pwr_en, safety_disable, amp_reg});
        end else begin
            board_rdata <= '0;
        end
    end

endmodule

// ==== design/motor_board.sv ====
module motor_board (
    input  logic                     sysclk,
    input  logic                     rst,
    // fw link
    input  board_pkg::reg_addr_t     fw_reg_raddr,
    input  board_pkg::reg_addr_t     fw_reg_waddr,
    input  board_pkg::reg_data_t     fw_reg_wdata,
    input  logic                     fw_reg_wen,
    input  logic                     fw_blk_wen,
    // eth link
    input  logic                     eth_read_en,
    input  board_pkg::reg_addr_t     eth_reg_raddr,
    input  board_pkg::reg_addr_t     eth_reg_waddr,
    input  board_pkg::reg_data_t     eth_reg_wdata,
    input  logic                     eth_reg_wen,
    input  logic                     eth_blk_wen,
    // adc feedback in, commands / enables out
    input  board_pkg::axis_cur_vec_t cur_fb,
    output board_pkg::reg_data_t     reg_rdata,
    output board_pkg::axis_cur_vec_t cur_cmd,
    output board_pkg::axis_mask_t    amp_enable,
    output logic                     fw_wr_drop
);

    // ------------------------------
    // shared register bus
    // ------------------------------
    board_pkg::reg_addr_t  reg_raddr;
    board_pkg::reg_addr_t  reg_waddr;
    board_pkg::reg_data_t  reg_wdata;
    logic                  reg_wen;
    logic                  blk_wen;
    board_pkg::reg_data_t  hub_rdata;       // per-peripheral read data
    board_pkg::reg_data_t  dac_rdata;
    board_pkg::reg_data_t  board_rdata;
    board_pkg::axis_mask_t safety_clear;    // board_regs -> safety_check
    board_pkg::axis_mask_t safety_disable;  // safety_check -> board_regs

    reg_bus_arbiter i_reg_bus_arbiter (
        .sysclk(sysclk), .rst(rst),
        .fw_reg_raddr(fw_reg_raddr), .fw_reg_waddr(fw_reg_waddr),
        .fw_reg_wdata(fw_reg_wdata), .fw_reg_wen(fw_reg_wen), .fw_blk_wen(fw_blk_wen),
        .eth_read_en(eth_read_en), .eth_reg_raddr(eth_reg_raddr),
        .eth_reg_waddr(eth_reg_waddr), .eth_reg_wdata(eth_reg_wdata),
        .eth_reg_wen(eth_reg_wen), .eth_blk_wen(eth_blk_wen),
        .hub_rdata(hub_rdata), .dac_rdata(dac_rdata), .board_rdata(board_rdata),
        .reg_raddr(reg_raddr), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .reg_wen(reg_wen), .blk_wen(blk_wen),
        .reg_rdata(reg_rdata), .fw_wr_drop(fw_wr_drop)
    );

    // ------------------------------
    // peripherals
    // ------------------------------
    hub_mem i_hub_mem (
        .sysclk(sysclk),
        .reg_raddr(reg_raddr), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .reg_wen(reg_wen), .blk_wen(blk_wen),
        .hub_rdata(hub_rdata)
    );

    dac_regs i_dac_regs (
        .sysclk(sysclk), .rst(rst),
        .reg_raddr(reg_raddr), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .reg_wen(reg_wen),
        .cur_cmd(cur_cmd), .dac_rdata(dac_rdata)
    );

    safety_check i_safety_check (
        .sysclk(sysclk), .rst(rst),
        .cur_fb(cur_fb), .cur_cmd(cur_cmd),
        .safety_clear(safety_clear), .safety_disable(safety_disable)
    );

    // channel 0
    board_regs i_board_regs (
        .sysclk(sysclk), .rst(rst),
        .reg_raddr(reg_raddr), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .reg_wen(reg_wen),
        .safety_disable(safety_disable), .safety_clear(safety_clear),
        .amp_enable(amp_enable), .board_rdata(board_rdata)
    );

endmodule

// ==== verification/tb_clock.sv ====
module tb_clock (
    output logic sysclk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;   // 100 ns period
    end

    // sync reset, held 8 cycles
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge sysclk);
        rst <= 1'b0;
    end

endmodule

// ==== verification/tb_motor_board.sv ====
`include "board_config.svh"

module tb_motor_board;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int OP_FW = 0, OP_ETH = 1, OP_BOTH = 2, OP_READ = 3, OP_HOLD = 4;

    typedef struct {
        int                       op;
        logic                     blk;        // fw block strobe instead of reg
        board_pkg::reg_addr_t     fw_addr;
        board_pkg::reg_data_t     fw_data;
        board_pkg::reg_addr_t     eth_addr;
        board_pkg::reg_data_t     eth_data;
        logic                     rd_eth;     // eth owns the read
        board_pkg::reg_addr_t     raddr;
        board_pkg::axis_cur_vec_t fb;
        logic                     chk_rd;
        board_pkg::reg_data_t     exp_rd;
        board_pkg::axis_cur_vec_t exp_cur;
        board_pkg::axis_mask_t    exp_amp;
        logic                     exp_drop;
    } entry_t;

    logic sysclk, rst;
    board_pkg::reg_addr_t     fw_reg_raddr, fw_reg_waddr, eth_reg_raddr, eth_reg_waddr;
    board_pkg::reg_data_t     fw_reg_wdata, eth_reg_wdata, reg_rdata;
    logic                     fw_reg_wen, fw_blk_wen, eth_read_en, eth_reg_wen, eth_blk_wen;
    board_pkg::axis_cur_vec_t cur_fb, cur_cmd;
    board_pkg::axis_mask_t    amp_enable;
    logic                     fw_wr_drop;

    entry_t                   tbl [128];
    int                       n_ent = 0;
    int                       errors = 0;
    int                       checks = 0;
    logic [31:0]              rng = 32'h5d16_160f;
    board_pkg::reg_data_t     hub_model [`HUB_DEPTH];
    board_pkg::axis_cur_vec_t cmd_m = '0;    // expected commands
    board_pkg::axis_mask_t    amp_m = '0;    // expected enables

    tb_clock i_tb_clock (.sysclk(sysclk), .rst(rst));

    motor_board i_motor_board (
        .sysclk(sysclk), .rst(rst),
        .fw_reg_raddr(fw_reg_raddr), .fw_reg_waddr(fw_reg_waddr),
        .fw_reg_wdata(fw_reg_wdata), .fw_reg_wen(fw_reg_wen), .fw_blk_wen(fw_blk_wen),
        .eth_read_en(eth_read_en), .eth_reg_raddr(eth_reg_raddr),
        .eth_reg_waddr(eth_reg_waddr), .eth_reg_wdata(eth_reg_wdata),
        .eth_reg_wen(eth_reg_wen), .eth_blk_wen(eth_blk_wen),
        .cur_fb(cur_fb), .reg_rdata(reg_rdata), .cur_cmd(cur_cmd),
        .amp_enable(amp_enable), .fw_wr_drop(fw_wr_drop)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // appends one row with expected cmd / amp from the running model
    task automatic add(input int op, input logic blk,
                       input board_pkg::reg_addr_t fa, input board_pkg::reg_data_t fd,
                       input board_pkg::reg_addr_t ea, input board_pkg::reg_data_t ed,
                       input logic rd_eth, input board_pkg::reg_addr_t ra,
                       input board_pkg::axis_cur_vec_t fb, input logic chk,
                       input board_pkg::reg_data_t exp, input logic drop);
        tbl[n_ent] = '{op, blk, fa, fd, ea, ed, rd_eth, ra, fb, chk, exp,
                       cmd_m, amp_m, drop};
        n_ent++;
    endtask

    task automatic check_data(input string name, input board_pkg::reg_data_t got,
                              input board_pkg::reg_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_cur(input string name, input board_pkg::axis_cur_vec_t got,
                             input board_pkg::axis_cur_vec_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_mask(input string name, input board_pkg::axis_mask_t got,
                              input board_pkg::axis_mask_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    // ------------------------------
    // table
    // ------------------------------
    task automatic build_table();
        board_pkg::reg_addr_t     hub_a;
        board_pkg::reg_data_t     d;
        board_pkg::axis_cur_vec_t quiet, over1;
        quiet = '0;
        over1 = '0;
        over1[0] = 16'h0201;                        // just past 2 * 0x0100
        hub_a = {`ADDR_HUB, 12'h000};
        add(OP_HOLD, 0, 0, 0, 0, 0, 0, 16'h0ff0, quiet, 0, 0, 0);
        add(OP_READ, 0, 0, 0, 0, 0, 0, 16'h0000, quiet, 1, 0, 0);   // status
        for (int a = 1; a <= `BOARD_NUM_AXES; a++)
            add(OP_READ, 0, 0, 0, 0, 0, 0, 16'(a * 16 + 1), quiet, 1, 0, 0);
        hub_model[63] = 32'h0;
        add(OP_FW, 0, hub_a | 16'h3f, 0, 0, 0, 0, 16'h0ff0, quiet, 0, 0, 0);
        add(OP_READ, 0, 0, 0, 0, 0, 1, hub_a | 16'h3f, quiet, 1, 0, 0);
        // hub block fill then back-to-back eth reads
        for (int k = 0; k < 8; k++) begin
            rng = xorshift(rng);
            hub_model[k] = rng;
            add(OP_FW, 1, hub_a | 16'(k), rng, 0, 0, 0, 16'h0ff0, quiet, 0, 0, 0);
        end
        for (int k = 0; k < 8; k++)
            add(OP_READ, 0, 0, 0, 0, 0, 1, hub_a | 16'(k), quiet, 1, hub_model[k], 0);
        // dac commands through eth
        for (int a = 1; a <= `BOARD_NUM_AXES; a++) begin
            d = 32'hdead_0000 | 32'(a * 16'h0100);   // upper half must be dropped
            cmd_m[a - 1] = d[15:0];
            add(OP_ETH, 0, 0, 0, 16'(a * 16 + 1), d, 0, 16'h0ff0, quiet, 0, 0, 0);
        end
        for (int a = 1; a <= `BOARD_NUM_AXES; a++)
            add(OP_READ, 0, 0, 0, 0, 0, 0, 16'(a * 16 + 1), quiet, 1,
                32'(cmd_m[a - 1]), 0);
        // fw write to axis 1 collides with eth and is lost
        cmd_m[1] = 16'h0222;
        add(OP_BOTH, 0, 16'h0011, 32'haaaa, 16'h0021, 32'h0222, 0, 16'h0ff0,
            quiet, 0, 0, 1);
        add(OP_HOLD, 0, 0, 0, 0, 0, 0, 16'h0ff0, quiet, 0, 0, 0);
        // power + all amps
        amp_m = 4'hf;
        add(OP_ETH, 0, 0, 0, 16'h0000, 32'h10f, 0, 16'h0ff0, quiet, 0, 0, 0);
        add(OP_READ, 0, 0, 0, 0, 0, 1, 16'h0000, quiet, 1, 32'h10f, 0);
        // short burst stays below the trip count
        for (int c = 0; c < `SAFETY_COUNT - 1; c++)
            add(OP_HOLD, 0, 0, 0, 0, 0, 0, 16'h0ff0, over1, 0, 0, 0);
        add(OP_READ, 0, 0, 0, 0, 0, 1, 16'h0000, quiet, 1, 32'h10f, 0);
        // full burst trips axis 1 on the last cycle
        for (int c = 0; c < `SAFETY_COUNT; c++) begin
            if (c == `SAFETY_COUNT - 1)
                amp_m = 4'he;
            add(OP_HOLD, 0, 0, 0, 0, 0, 0, 16'h0ff0, over1, 0, 0, 0);
        end
        add(OP_HOLD, 0, 0, 0, 0, 0, 0, 16'h0ff0, quiet, 0, 0, 0);
        add(OP_READ, 0, 0, 0, 0, 0, 1, 16'h0000, quiet, 1, 32'h11f, 0);
        // only the axis 1 amp bit written, so pwr drops and no pwr pulse helps
        amp_m = 4'h0;
        add(OP_ETH, 0, 0, 0, 16'h0000, 32'h001, 0, 16'h0ff0, quiet, 0, 0, 0);
        add(OP_READ, 0, 0, 0, 0, 0, 0, 16'h0000, quiet, 1, 32'h001, 0);
        amp_m = 4'hf;                               // power and all amps back on
        add(OP_ETH, 0, 0, 0, 16'h0000, 32'h10f, 0, 16'h0ff0, quiet, 0, 0, 0);
        add(OP_READ, 0, 0, 0, 0, 0, 1, 16'h0000, quiet, 1, 32'h10f, 0);
    endtask

    task automatic drive(input entry_t e);
        fw_reg_waddr  <= e.fw_addr;
        fw_reg_wdata  <= e.fw_data;
        eth_reg_waddr <= e.eth_addr;
        eth_reg_wdata <= e.eth_data;
        fw_reg_wen    <= (e.op == OP_FW || e.op == OP_BOTH) && !e.blk;
        fw_blk_wen    <= (e.op == OP_FW) && e.blk;
        eth_reg_wen   <= (e.op == OP_ETH || e.op == OP_BOTH);
        eth_blk_wen   <= 1'b0;
        eth_read_en   <= e.rd_eth;
        // the idle link points elsewhere so a wrong mux shows up
        fw_reg_raddr  <= e.rd_eth ? 16'h0011 : e.raddr;
        eth_reg_raddr <= e.rd_eth ? e.raddr : 16'h0021;
        cur_fb        <= e.fb;
    endtask

    initial begin
        fw_reg_raddr = '0;
        fw_reg_waddr = '0;
        fw_reg_wdata = '0;
        fw_reg_wen = 1'b0;
        fw_blk_wen = 1'b0;
        eth_read_en = 1'b0;
        eth_reg_raddr = '0;
        eth_reg_waddr = '0;
        eth_reg_wdata = '0;
        eth_reg_wen = 1'b0;
        eth_blk_wen = 1'b0;
        cur_fb = '0;
        build_table();
        wait (rst === 1'b0);
        // row i driven here and checked one edge later
        for (int i = 0; i <= n_ent; i++) begin
            @(posedge sysclk);
            if (i < n_ent)
                drive(tbl[i]);
            else
                drive(tbl[0]);      // idle row while the last one settles
            @(negedge sysclk);
            if (i > 0) begin
                if (tbl[i - 1].chk_rd)
                    check_data("reg_rdata", reg_rdata, tbl[i - 1].exp_rd);
                check_cur("cur_cmd", cur_cmd, tbl[i - 1].exp_cur);
                check_mask("amp_enable", amp_enable, tbl[i - 1].exp_amp);
                check_bit("fw_wr_drop", fw_wr_drop, tbl[i - 1].exp_drop);
            end
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    // watchdog
    initial begin
        #1;
        repeat (n_ent * 20) @(posedge sysclk);
        $display("timeout: the table did not finish in time");
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== motor_board.f ====
+incdir+include
design/board_pkg.sv
design/reg_bus_arbiter.sv
design/hub_mem.sv
design/dac_regs.sv
design/safety_check.sv
design/board_regs.sv
design/motor_board.sv
verification/tb_clock.sv
verification/tb_motor_board.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_motor_board
FLIST     ?= motor_board.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
